// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // pc and instruction width
    localparam int xlen = 32;

    // major opcode of the unconditional B
    localparam logic [5:0] b_opcode = 6'b010100;

    // three-register format
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg3_t;

    // 26-bit branch offset, split low half above high half
    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_branch_t;

    // one instruction word, seen either way
    typedef union packed {
        inst_reg3_t   reg3;
        inst_branch_t branch;
    } inst_word_u;

    // IF to predecode payload
    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_word_u      inst;
    } if_to_id_t;

    // decode output payload
    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_word_u      inst;
        logic            is_branch;
    } dec_out_t;

    // fetch redirect from predecode
    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    // register offsets on the APB side
    localparam logic [7:0] reg_ctrl         = 8'h00;
    localparam logic [7:0] reg_load_addr    = 8'h04;
    localparam logic [7:0] reg_load_data    = 8'h08;
    localparam logic [7:0] reg_fetch_count  = 8'h0C;
    localparam logic [7:0] reg_branch_count = 8'h10;
    localparam logic [7:0] reg_last_pc      = 8'h14;

endpackage

`default_nettype wire

// ==== logic/if_stage.sv ====
`default_nettype none

module if_stage #(
    parameter logic [fetch_pkg::xlen-1:0] boot_pc = 32'h1C00_0000,
    parameter int ram_words = 256
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            enable,
    input  fetch_pkg::redirect_t            redirect,
    input  logic                            id_allowin,
    output logic                            ram_en,
    output logic [$clog2(ram_words)-1:0]    ram_addr,
    input  logic [fetch_pkg::xlen-1:0]      ram_rdata,
    output logic                            if_valid,
    output fetch_pkg::if_to_id_t            if_data
);

    localparam int addr_w = $clog2(ram_words);

    logic [fetch_pkg::xlen-1:0] pc;
    logic [fetch_pkg::xlen-1:0] seq_pc;
    logic [fetch_pkg::xlen-1:0] next_pc;
    logic                       valid;
    logic                       allowin;

    // stage is free when empty or when predecode takes the held word
    assign allowin = ~valid | id_allowin;
    assign ram_en  = allowin & enable;

    assign seq_pc  = pc + 32'd4;
    assign next_pc = redirect.taken ? redirect.target : seq_pc;

    // word index into the RAM, wraps over the depth
    assign ram_addr = next_pc[addr_w+1:2];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (allowin) begin
            // data for a request shows up next cycle
            valid <= ram_en;
        end else if (redirect.taken) begin
            valid <= 1'b0;
        end
    end

    // pc follows the address that was actually requested
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= boot_pc - 32'd4;
        end else if (ram_en) begin
            pc <= next_pc;
        end else if (allowin && redirect.taken) begin
            // fetch is paused, park so that the next request hits the target
            pc <= redirect.target - 32'd4;
        end
    end

    assign if_valid     = valid;
    assign if_data.pc   = pc;
    assign if_data.inst = fetch_pkg::inst_word_u'(ram_rdata);

endmodule

`default_nettype wire

// ==== logic/inst_ram.sv ====
`default_nettype none

module inst_ram #(
    parameter int ram_words = 256
) (
    input  logic                            clk,
    input  logic                            en,
    input  logic [$clog2(ram_words)-1:0]    addr,
    output logic [fetch_pkg::xlen-1:0]      rdata,
    input  logic                            we,
    input  logic [$clog2(ram_words)-1:0]    waddr,
    input  logic [fetch_pkg::xlen-1:0]      wdata
);

    localparam int addr_w = $clog2(ram_words);

    logic [fetch_pkg::xlen-1:0] mem [ram_words];

    logic [addr_w-1:0] rd_idx;
    logic [addr_w-1:0] wr_idx;

    assign rd_idx = addr;
    assign wr_idx = waddr;

    // program load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= wdata;
        end
    end

    // registered read, output holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/branch_predecode.sv ====
`default_nettype none

module branch_predecode (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    if_valid,
    input  fetch_pkg::if_to_id_t    if_data,
    output logic                    id_allowin,
    output logic                    dec_valid,
    output fetch_pkg::dec_out_t     dec_out,
    input  logic                    dec_ready,
    output fetch_pkg::redirect_t    redirect
);

    fetch_pkg::if_to_id_t       entry;
    logic                       valid;
    logic                       take_in;
    logic                       is_b;
    logic [fetch_pkg::xlen-1:0] offset;

    // single entry, refills in the same cycle it drains
    assign id_allowin = ~valid | dec_ready;

    // the word behind a leaving B is on the wrong path
    assign take_in = if_valid & id_allowin & ~redirect.taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (id_allowin) begin
            valid <= take_in;
        end
    end

    always_ff @(posedge clk) begin
        if (take_in) begin
            entry <= if_data;
        end
    end

    assign is_b = (entry.inst.branch.op6 == fetch_pkg::b_opcode);

    // offs_hi carries the sign, word offset becomes a byte offset
    assign offset = {{4{entry.inst.branch.offs_hi[9]}},
                     entry.inst.branch.offs_hi,
                     entry.inst.branch.offs_lo,
                     2'b00};

    // redirect only when the branch actually leaves
    assign redirect.taken  = valid & dec_ready & is_b;
    assign redirect.target = entry.pc + offset;

    assign dec_valid         = valid;
    assign dec_out.pc        = entry.pc;
    assign dec_out.inst      = entry.inst;
    assign dec_out.is_branch = is_b;

endmodule

`default_nettype wire

// ==== logic/fetch_csr.sv ====
`default_nettype none

module fetch_csr #(
    parameter int ram_words = 256
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [7:0]                      paddr,
    input  logic [fetch_pkg::xlen-1:0]      pwdata,
    output logic [fetch_pkg::xlen-1:0]      prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            enable,
    output logic                            ram_we,
    output logic [$clog2(ram_words)-1:0]    ram_waddr,
    output logic [fetch_pkg::xlen-1:0]      ram_wdata,
    input  logic                            dec_valid,
    input  logic                            dec_ready,
    input  fetch_pkg::dec_out_t             dec_out
);

    localparam int addr_w = $clog2(ram_words);

    logic [addr_w-1:0]          load_addr;
    logic [fetch_pkg::xlen-1:0] fetch_count;
    logic [fetch_pkg::xlen-1:0] branch_count;
    logic [fetch_pkg::xlen-1:0] last_pc;
    logic                       access;
    logic                       mapped;
    logic                       read_only;
    logic                       wr;
    logic                       accepted;

    // access phase only, never waits
    assign access = psel & penable;
    assign pready = 1'b1;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata    = '0;
        case (paddr)
            fetch_pkg::reg_ctrl:         prdata = {31'b0, enable};
            fetch_pkg::reg_load_addr:    prdata = 32'(load_addr);
            fetch_pkg::reg_load_data:    prdata = '0;
            fetch_pkg::reg_fetch_count: begin
                read_only = 1'b1;
                prdata    = fetch_count;
            end
            fetch_pkg::reg_branch_count: begin
                read_only = 1'b1;
                prdata    = branch_count;
            end
            fetch_pkg::reg_last_pc: begin
                read_only = 1'b1;
                prdata    = last_pc;
            end
            default: mapped = 1'b0;
        endcase
    end

    assign pslverr = access & (~mapped | (pwrite & read_only));
    assign wr      = access & pwrite & ~pslverr;

    // program load goes straight to the RAM write port
    assign ram_we    = wr & (paddr == fetch_pkg::reg_load_data);
    assign ram_waddr = load_addr;
    assign ram_wdata = pwdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            enable    <= 1'b0;
            load_addr <= '0;
        end else if (wr) begin
            if (paddr == fetch_pkg::reg_ctrl) begin
                enable <= pwdata[0];
            end
            if (paddr == fetch_pkg::reg_load_addr) begin
                load_addr <= pwdata[addr_w-1:0];
            end
            if (ram_we) begin
                // auto-increment, wraps at the memory depth
                load_addr <= (load_addr == addr_w'(ram_words - 1)) ? '0 : load_addr + 1'b1;
            end
        end
    end

    // result counters, fed by the decode output handshake
    assign accepted = dec_valid & dec_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_count  <= '0;
            branch_count <= '0;
            last_pc      <= '0;
        end else if (accepted) begin
            fetch_count <= fetch_count + 1'b1;
            last_pc     <= dec_out.pc;
            if (dec_out.is_branch) begin
                branch_count <= branch_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`default_nettype none

module fetch_top #(
    parameter logic [fetch_pkg::xlen-1:0] boot_pc = 32'h1C00_0000,
    parameter int ram_words = 256
) (
    input  logic                        clk,
    input  logic                        resetn,
    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [7:0]                  paddr,
    input  logic [fetch_pkg::xlen-1:0]  pwdata,
    output logic [fetch_pkg::xlen-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    // decoded instruction stream
    output logic                        dec_valid,
    input  logic                        dec_ready,
    output fetch_pkg::dec_out_t         dec_out
);

    localparam int addr_w = $clog2(ram_words);

    logic                       enable;
    fetch_pkg::redirect_t       redirect;
    logic                       id_allowin;
    logic                       ram_en;
    logic [addr_w-1:0]          ram_addr;
    logic [fetch_pkg::xlen-1:0] ram_rdata;
    logic                       ram_we;
    logic [addr_w-1:0]          ram_waddr;
    logic [fetch_pkg::xlen-1:0] ram_wdata;
    logic                       if_valid;
    fetch_pkg::if_to_id_t       if_data;

    if_stage #(
        .boot_pc   (boot_pc),
        .ram_words (ram_words)
    ) u_if_stage (
        .clk        (clk),
        .resetn     (resetn),
        .enable     (enable),
        .redirect   (redirect),
        .id_allowin (id_allowin),
        .ram_en     (ram_en),
        .ram_addr   (ram_addr),
        .ram_rdata  (ram_rdata),
        .if_valid   (if_valid),
        .if_data    (if_data)
    );

    inst_ram #(
        .ram_words (ram_words)
    ) u_inst_ram (
        .clk   (clk),
        .en    (ram_en),
        .addr  (ram_addr),
        .rdata (ram_rdata),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata)
    );

    branch_predecode u_branch_predecode (
        .clk        (clk),
        .resetn     (resetn),
        .if_valid   (if_valid),
        .if_data    (if_data),
        .id_allowin (id_allowin),
        .dec_valid  (dec_valid),
        .dec_out    (dec_out),
        .dec_ready  (dec_ready),
        .redirect   (redirect)
    );

    fetch_csr #(
        .ram_words (ram_words)
    ) u_fetch_csr (
        .clk       (clk),
        .resetn    (resetn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .enable    (enable),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_out   (dec_out)
    );

endmodule

`default_nettype wire

// ==== verif/fetch_properties.sv ====
`default_nettype none

module fetch_properties (
    input logic                 clk,
    input logic                 resetn,
    input logic                 dec_valid,
    input logic                 dec_ready,
    input fetch_pkg::dec_out_t  dec_out,
    input fetch_pkg::redirect_t redirect
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned                fails = 0;
    logic                       target_due;
    logic [fetch_pkg::xlen-1:0] target;

    // remember where the last taken branch went
    always_ff @(posedge clk) begin
        if (!resetn) begin
            target_due <= 1'b0;
        end else if (redirect.taken) begin
            target_due <= 1'b1;
            target     <= redirect.target;
        end else if (dec_valid) begin
            target_due <= 1'b0;
        end
    end

    // payload holds while the consumer stalls
    stall_stable: assert property (@(posedge clk) disable iff (!resetn)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_out))
    else begin
        $error("dec_out changed while the decode port was stalled");
        fails++;
    end

    // the word IF offered behind a taken branch never reaches the output
    wrong_path_dropped: assert property (@(posedge clk) disable iff (!resetn)
        redirect.taken |=> !dec_valid)
    else begin
        $error("decode port valid in the cycle right after a redirect");
        fails++;
    end

    // first output after a redirect sits at the branch target
    target_next: assert property (@(posedge clk) disable iff (!resetn)
        target_due && dec_valid |-> dec_out.pc == target)
    else begin
        $error("output after a redirect is not at the branch target");
        fails++;
    end

endmodule

bind branch_predecode fetch_properties u_fetch_properties (
    .clk       (clk),
    .resetn    (resetn),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_out   (dec_out),
    .redirect  (redirect)
);

`default_nettype wire

// ==== verif/fetch_tb.sv ====
`default_nettype none

module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_out        = 30;
    localparam int reset_cycles = 10;

    logic                clk;
    logic                resetn;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [7:0]          paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    logic                dec_valid;
    logic                dec_ready;
    fetch_pkg::dec_out_t dec_out;

    // program table, one row per RAM word
    string       tab_name[$];
    int          tab_idx[$];
    logic [31:0] tab_word[$];
    bit          tab_b[$];
    int          tab_step[$];

    logic [31:0] boot_pc;
    int          boot_idx;
    int          ram_words;
    logic [31:0] rng = 32'h4bb6_8eb5;
    int          cycles = 0;
    int          limit;

    // reference model state
    logic [31:0]         model_pc;
    int                  model_count = 0;
    int                  model_branches = 0;
    logic [31:0]         model_last_pc = '0;
    bit                  stalled = 1'b0;
    fetch_pkg::dec_out_t held;

    fetch_top uut (
        .clk       (clk),
        .resetn    (resetn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_out   (dec_out)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            fail_run("run exceeded its cycle limit without finishing");
        end
        if (uut.u_branch_predecode.u_fetch_properties.fails != 0) begin
            fail_run("an assertion on the decode port or the redirect failed");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [64:0] expected,
                         input logic [64:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: expected %0h, actual %0h",
                               name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // add.w rd, rj, rk
    function automatic logic [31:0] add_word(input int rd, input int rj, input int rk);
        return {17'h00020, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    // B takes a signed word offset, low 16 bits stored first
    function automatic logic [31:0] b_word(input int offs);
        logic [25:0] o;
        o = 26'(offs);
        return {6'b010100, o[15:0], o[25:16]};
    endfunction

    // val is the word offset of a B, or rd of an add
    task automatic add_row(input string name, input int k, input bit is_b, input int val);
        tab_name.push_back(name);
        tab_idx.push_back((boot_idx + k) % ram_words);
        tab_word.push_back(is_b ? b_word(val) : add_word(val, val + 1, val + 2));
        tab_b.push_back(is_b);
        tab_step.push_back(is_b ? val : 1);
    endtask

    function automatic int find_row(input logic [31:0] pc);
        for (int i = 0; i < tab_idx.size(); i++) begin
            if (tab_idx[i] == int'((pc >> 2) % ram_words)) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // one APB transfer, data is the write value or the expected read value
    task automatic apb_xfer(input string name, input logic write, input logic [7:0] addr,
                            input logic [31:0] data, input logic exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = write ? data : '0;
        step();
        penable = 1'b1;
        @(negedge clk);
        check({name, " pready"}, 1, pready);
        check({name, " pslverr"}, exp_err, pslverr);
        if (!write && !exp_err) begin
            check({name, " prdata"}, data, prdata);
        end
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // decode port, sampled at the falling edge
    task automatic observe();
        int r;
        if (stalled) begin
            check("stall keeps dec_valid", 1, dec_valid);
            check("stall keeps dec_out", held, dec_out);
        end
        if (dec_valid && dec_ready) begin
            r = find_row(model_pc);
            if (r < 0) begin
                fail_run("reference model left the loaded program");
            end else begin
                check({tab_name[r], " pc"}, model_pc, dec_out.pc);
                check({tab_name[r], " inst"}, tab_word[r], dec_out.inst);
                check({tab_name[r], " is_branch"}, tab_b[r], dec_out.is_branch);
                model_count++;
                model_branches += tab_b[r];
                model_last_pc = model_pc;
                model_pc      = model_pc + 32'(tab_step[r] * 4);
            end
        end
        stalled = dec_valid && !dec_ready;
        held    = dec_out;
    endtask

    initial begin
        int cur;
        int drained;
        clk       = 1'b0;
        resetn    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        dec_ready = 1'b0;
        boot_pc   = uut.boot_pc;
        ram_words = uut.ram_words;
        boot_idx  = int'((boot_pc >> 2) % ram_words);
        model_pc  = boot_pc;

        // stream: 0 1 6 7 2 3 9 10 then back to 0
        add_row("seq_head", 0, 0, 1);
        add_row("b_fwd", 1, 1, 5);
        add_row("loop_top", 2, 0, 4);
        add_row("b_exit", 3, 1, 6);
        add_row("skip_a", 4, 0, 7);
        add_row("skip_b", 5, 0, 10);
        add_row("fwd_land", 6, 0, 13);
        add_row("b_back", 7, 1, -5);
        add_row("shadow_a", 8, 0, 16);
        add_row("exit_land", 9, 0, 19);
        add_row("b_restart", 10, 1, -10);
        add_row("shadow_b", 11, 0, 22);
        limit = 40 * n_out + 3 * (tab_idx.size() + 40) + reset_cycles;

        repeat (reset_cycles) @(posedge clk);
        #2;
        resetn = 1'b1;
        @(negedge clk);
        check("dec_valid after reset", 0, dec_valid);
        check("pslverr after reset", 0, pslverr);
        step();

        // program load, rows are contiguous from the first index
        cur = tab_idx[0];
        apb_xfer("set load_addr", 1, fetch_pkg::reg_load_addr, cur, 0);
        foreach (tab_idx[i]) begin
            apb_xfer({"load ", tab_name[i]}, 1, fetch_pkg::reg_load_data, tab_word[i], 0);
        end
        cur = (cur + tab_idx.size()) % ram_words;
        apb_xfer("load_addr readback", 0, fetch_pkg::reg_load_addr, cur, 0);
        apb_xfer("load_data reads zero", 0, fetch_pkg::reg_load_data, 0, 0);

        // illegal accesses change nothing
        apb_xfer("write fetch_count", 1, fetch_pkg::reg_fetch_count, 32'h55, 1);
        apb_xfer("write last_pc", 1, fetch_pkg::reg_last_pc, 32'h1234, 1);
        apb_xfer("write unmapped", 1, 8'h20, 32'h7, 1);
        apb_xfer("read unmapped", 0, 8'h18, 0, 1);
        apb_xfer("fetch_count untouched", 0, fetch_pkg::reg_fetch_count, 0, 0);
        apb_xfer("last_pc untouched", 0, fetch_pkg::reg_last_pc, 0, 0);
        apb_xfer("load_addr untouched", 0, fetch_pkg::reg_load_addr, cur, 0);

        repeat (16) begin
            @(negedge clk);
            check("idle while disabled", 0, dec_valid);
        end
        step();

        apb_xfer("enable fetch", 1, fetch_pkg::reg_ctrl, 1, 0);
        while (model_count < n_out) begin
            rng       = xorshift(rng);
            dec_ready = (rng[1:0] != 2'b00);
            @(negedge clk);
            observe();
            step();
        end
        dec_ready = 1'b0;
        apb_xfer("disable fetch", 1, fetch_pkg::reg_ctrl, 0, 0);

        // at most the IF and predecode words are left in flight
        drained   = model_count;
        dec_ready = 1'b1;
        repeat (8) begin
            @(negedge clk);
            observe();
        end
        check("words in flight after disable", 1, (model_count - drained) <= 2);
        check("quiet after drain", 0, dec_valid);
        step();
        dec_ready = 1'b0;

        apb_xfer("fetch_count", 0, fetch_pkg::reg_fetch_count, model_count, 0);
        apb_xfer("branch_count", 0, fetch_pkg::reg_branch_count, model_branches, 0);
        apb_xfer("last_pc", 0, fetch_pkg::reg_last_pc, model_last_pc, 0);
        check("assertion failures", 0, uut.u_branch_predecode.u_fetch_properties.fails);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/fetch_pkg.sv
logic/if_stage.sv
logic/inst_ram.sv
logic/branch_predecode.sv
logic/fetch_csr.sv
logic/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - target: any(rtl, test)
    files:
      - logic/fetch_pkg.sv
      - logic/if_stage.sv
      - logic/inst_ram.sv
      - logic/branch_predecode.sv
      - logic/fetch_csr.sv
      - logic/fetch_top.sv
  - target: test
    files:
      - verif/fetch_properties.sv
      - verif/fetch_tb.sv
